//--- Bender.yml
package:
  name: uartTop

sources:
  - include_dirs:
      - logic
    files:
      - logic/uartPkg.sv
      - logic/holdReg.sv
      - logic/hostRegs.sv
      - logic/uartTx.sv
      - logic/uartRx.sv
      - logic/uartTop.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/uartTopTb.sv

//--- logic/holdReg.sv
/*
  One-entry holding register between a producer and a consumer. load
  fills it, take empties it, flush empties it unconditionally. Used for
  the transmit character and for the received entry.
*/
`timescale 1ns/1ps
`default_nettype none

module holdReg #(
  parameter type payloadT = logic [7:0]
) (
  input  wire logic    BRCLK,
  input  wire logic    cmd_resetError,
  input  wire logic    load,             // Producer strobe
  input  wire payloadT loadData,
  input  wire logic    take,             // Consumer strobe
  input  wire logic    flush,            // Held while the channel is off
  output payloadT      data,
  output logic         full
);

  // ------------------------------------------------------------
  // Full flag
  // ------------------------------------------------------------
  always_ff @(posedge BRCLK) begin
    if (cmd_resetError) begin
      full <= 1'b0;
    end else if (flush) begin
      full <= 1'b0;                      // Disable wins over everything
    end else if (load) begin
      full <= 1'b1;                      // Load beats a same-cycle take
    end else if (take) begin
      full <= 1'b0;
    end
  end

  // Payload, a new load simply overwrites
  always_ff @(posedge BRCLK) begin
    if (load) begin
      data <= loadData;
    end
  end

endmodule

`default_nettype wire

//--- logic/hostRegs.sv
/*
  CPU side of the UART. Decodes single-cycle bus strobes, keeps the command
  register, the error and transmitter-empty flags and the read data latch,
  and drives the modem and ready pins. The THR data goes straight from the
  bus to the transmit holding register; only its load strobe comes from here.
*/
`timescale 1ns/1ps
`default_nettype none

`include "uartTiming_consts.svh"

module hostRegs (
  input  wire logic             BRCLK,
  input  wire logic             cmd_resetError,
  input  wire logic             ceN,
  input  wire logic             readN,
  input  wire logic [1:0]       address,
  input  wire uartPkg::charT    dataIn,
  output uartPkg::charT         dataOut,
  output logic                  thrLoad,
  input  wire logic             thrFull,
  output logic                  rhrTake,
  output logic                  rhrFlush,
  input  wire logic             rhrLoad,
  input  wire logic             rhrFull,
  input  wire uartPkg::rxEntryT rhrEntry,
  input  wire logic             txIdle,
  output logic                  txEn,
  output logic                  rxEn,
  output logic                  loopback,
  output logic                  dtrN,
  output logic                  rtsN,
  output logic                  rxRdyN,
  output logic                  txRdyN,
  output logic                  txEmtN
);

  import uartPkg::*;

  cmdT        cmd;                       // Command register
  cmdT        wrCmd;                     // Bus data seen as a command
  statusT     status;
  logic [7:0] statusBits;
  logic       busWrite;
  logic       busRead;
  logic       overrun;
  logic       frameErr;
  logic       txEmt;
  logic       txIdleQ;                   // Previous txIdle
  logic       txFinish;                  // Transmitter just went idle
  logic       rhrLoadQ;                  // Previous rhrLoad, new entry now held

  // ------------------------------------------------------------
  // Bus decode
  // ------------------------------------------------------------
  assign busWrite = !ceN && readN;
  assign busRead  = !ceN && !readN;
  assign wrCmd    = cmdT'(dataIn);

  assign thrLoad  = busWrite && (address == `ADDR_DATA);   // Write THR
  assign rhrTake  = busRead && (address == `ADDR_DATA);    // Read RHR
  assign rhrFlush = !cmd.rxEn;                             // RHR empty while off

  assign txEn     = cmd.txEn;
  assign rxEn     = cmd.rxEn;
  assign loopback = (cmd.mode == LOCAL_LOOP);              // Only mode that acts

  assign txFinish = txIdle && !txIdleQ;

  // Status byte from the flags and the two full bits
  always_comb begin
    statusBits               = '0;
    statusBits[`SR_THRE]     = cmd.txEn && !thrFull;       // Zero while disabled
    statusBits[`SR_RXRDY]    = rhrFull;
    statusBits[`SR_TXEMT]    = txEmt;
    statusBits[`SR_OVERRUN]  = overrun;
    statusBits[`SR_FRAMEERR] = frameErr;
  end

  assign status = statusT'(statusBits);

  // ------------------------------------------------------------
  // Registers and flags
  // ------------------------------------------------------------
  always_ff @(posedge BRCLK) begin
    if (cmd_resetError) begin
      cmd      <= '0;
      overrun  <= 1'b0;
      frameErr <= 1'b0;
      txEmt    <= 1'b0;
      txIdleQ  <= 1'b1;                  // Idle out of reset so no false finish
      rhrLoadQ <= 1'b0;
      dataOut  <= '0;
    end else begin
      txIdleQ  <= txIdle;
      rhrLoadQ <= rhrLoad;

      if (busWrite && (address == `ADDR_CMD)) begin
        cmd <= wrCmd;
        if (wrCmd.clrErr) begin          // Uses the written bit
          overrun  <= 1'b0;
          frameErr <= 1'b0;
        end
      end

      // New errors win over a same-cycle clear
      if (rhrLoad && rhrFull && !rhrTake) overrun <= 1'b1;
      if (rhrLoadQ && rhrEntry.frameErr) frameErr <= 1'b1;   // Entry held one cycle on

      if (busRead && (address == `ADDR_STATUS)) txEmt <= 1'b0;
      if (txFinish && !thrFull) txEmt <= 1'b1;    // Nothing waiting behind it

      if (busRead) begin
        case (address)
          `ADDR_DATA:   dataOut <= rhrEntry.ch;
          `ADDR_STATUS: dataOut <= charT'(status);
          `ADDR_MODE:   dataOut <= '0;             // Mode regs not built
          `ADDR_CMD:    dataOut <= charT'(cmd);
        endcase
      end
    end
  end

  // ------------------------------------------------------------
  // Active-low pins
  // ------------------------------------------------------------
  assign dtrN   = !cmd.dtrLow;
  assign rtsN   = !cmd.rtsLow;
  assign rxRdyN = cmd.rxEn ? !status.rxRdy : 1'b1;
  assign txRdyN = cmd.txEn ? !status.thrE : 1'b1;
  assign txEmtN = !status.txEmt;

endmodule

`default_nettype wire

//--- logic/uartPkg.sv
/*
  Shared types of the UART. The character and receive-entry types are the
  payloads of the two holding registers; cmdT and statusT lay out the host
  registers bit for bit.
*/
`default_nettype none

package uartPkg;

  // ------------------------------------------------------------
  // Payloads
  // ------------------------------------------------------------
  typedef logic [7:0] charT;         // One 8N1 character

  typedef struct packed {
    logic frameErr;                  // Stop bit was low
    charT ch;                        // Received data bits
  } rxEntryT;

  // ------------------------------------------------------------
  // Host registers
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    NORMAL      = 2'b00,
    ECHO        = 2'b01,             // Treated as normal
    LOCAL_LOOP  = 2'b10,             // TXD fed to the receiver
    REMOTE_LOOP = 2'b11              // Treated as normal
  } modeT;

  typedef struct packed {
    modeT mode;                      // Bits 7:6
    logic rtsLow;                    // Drive RTS pin low
    logic clrErr;                    // Clears overrun and frame error on write
    logic spare;                     // Break on the real part, readback only
    logic rxEn;                      // Receiver enable
    logic dtrLow;                    // Drive DTR pin low
    logic txEn;                      // Transmitter enable
  } cmdT;

  typedef struct packed {
    logic [1:0] rsvdHi;              // DSR/DCD on the real part, always 0
    logic       frameErr;
    logic       overrun;
    logic       rsvdParity;          // Parity error not built
    logic       txEmt;
    logic       rxRdy;
    logic       thrE;
  } statusT;

endpackage

`default_nettype wire

//--- logic/uartRx.sv
/*
  Receive sampler. Picks the loopback or external line, qualifies the start
  bit at mid-bit, samples 8 data bits LSB first and the stop bit, and pulses
  done with the finished entry. A low stop bit sets the frame-error flag.
*/
`timescale 1ns/1ps
`default_nettype none

`include "uartTiming_consts.svh"

module uartRx (
  input  wire logic    BRCLK,
  input  wire logic    cmd_resetError,
  input  wire logic    enable,
  input  wire logic    loopback,            // LOCAL_LOOP selected
  input  wire logic    rxd,
  input  wire logic    txdLoop,             // Own transmitter output
  output logic         done,
  output uartPkg::rxEntryT entry
);

  import uartPkg::*;

  localparam int CntW = $clog2(`BIT_TICKS);

  typedef enum logic [1:0] {IDLE, START, DATA, STOP} rxStateT;

  rxStateT         state;
  logic [CntW-1:0] tickCnt;
  logic [2:0]      bitIdx;
  logic            line;
  logic            bitEnd;                  // Middle of a data or stop bit
  logic            halfEnd;                 // Middle of the start bit

  // ------------------------------------------------------------
  // Line select and sample points
  // ------------------------------------------------------------
  assign line    = loopback ? txdLoop : rxd;
  assign bitEnd  = (tickCnt == CntW'(`BIT_TICKS - 1));
  assign halfEnd = (tickCnt == CntW'(`HALF_TICKS - 1));

  // ------------------------------------------------------------
  // Frame FSM
  // ------------------------------------------------------------
  always_ff @(posedge BRCLK) begin
    if (cmd_resetError || !enable) begin
      state   <= IDLE;
      tickCnt <= '0;
      bitIdx  <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;                         // Single-cycle pulse
      case (state)
        IDLE: begin
          tickCnt <= '0;
          if (!line) state <= START;        // Falling edge seen
        end
        START: begin
          if (halfEnd) begin
            tickCnt <= '0;
            bitIdx  <= '0;
            state   <= line ? IDLE : DATA;  // Glitch, back to hunting
          end else begin
            tickCnt <= tickCnt + 1'b1;
          end
        end
        DATA: begin
          if (bitEnd) begin
            tickCnt <= '0;
            bitIdx  <= bitIdx + 3'd1;
            if (bitIdx == 3'd7) state <= STOP;
          end else begin
            tickCnt <= tickCnt + 1'b1;
          end
        end
        STOP: begin
          if (bitEnd) begin
            tickCnt <= '0;
            done    <= 1'b1;                // 153 cycles after the start edge
            state   <= IDLE;
          end else begin
            tickCnt <= tickCnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Shift in LSB first, check stop bit
  always_ff @(posedge BRCLK) begin
    if (state == DATA && bitEnd) begin
      entry.ch <= {line, entry.ch[7:1]};
    end
    if (state == STOP && bitEnd) begin
      entry.frameErr <= !line;              // Stop must be high
    end
  end

endmodule

`default_nettype wire

//--- logic/uartTiming_consts.svh
/*
  Bit timing, register addresses and status bit positions of the UART.
  Include this in any module that decodes the bus or counts bit times.
*/
`ifndef UART_TIMING_CONSTS_SVH
`define UART_TIMING_CONSTS_SVH

// ------------------------------------------------------------
// Bit timing in BRCLK cycles
// ------------------------------------------------------------
`define BIT_TICKS  16        // One serial bit
`define HALF_TICKS 8         // Start edge to middle of start bit

// ------------------------------------------------------------
// Host register map
// ------------------------------------------------------------
`define ADDR_DATA   2'd0     // THR on write, RHR on read
`define ADDR_STATUS 2'd1     // Status, read only
`define ADDR_MODE   2'd2     // Mode registers not built, reads zero
`define ADDR_CMD    2'd3     // Command register

// Status register bit positions
`define SR_THRE     0        // Transmit holding register empty
`define SR_RXRDY    1        // Receive holding register full
`define SR_TXEMT    2        // Transmitter shift side empty
`define SR_OVERRUN  4        // Character lost in RHR
`define SR_FRAMEERR 5        // Stop bit sampled low

`endif

//--- logic/uartTop.sv
/*
  UART top level. Host register block feeds the transmit holding register
  and transmitter; the receiver feeds the receive holding register, which
  the host block reads back. Instances and wires only.
*/
`timescale 1ns/1ps
`default_nettype none

module uartTop (
  input  wire logic          BRCLK,
  input  wire logic          cmd_resetError,   // Synchronous master reset
  input  wire logic          ceN,
  input  wire logic          readN,
  input  wire logic [1:0]    address,
  input  wire uartPkg::charT dataIn,
  output uartPkg::charT      dataOut,
  input  wire logic          rxd,
  output logic               txd,
  output logic               dtrN,
  output logic               rtsN,
  output logic               rxRdyN,
  output logic               txRdyN,
  output logic               txEmtN
);

  import uartPkg::*;

  // ------------------------------------------------------------
  // Internal wires
  // ------------------------------------------------------------
  logic    thrLoad, thrFull, thrTake;      // Transmit side strobes
  charT    thrData;
  logic    rhrLoad, rhrFull, rhrTake, rhrFlush;
  rxEntryT rxEntry;                        // Receiver output
  rxEntryT rhrEntry;                       // Held entry for the host
  logic    txEn, rxEn, loopback, txIdle;

  hostRegs u_hostRegs (
    .BRCLK, .cmd_resetError, .ceN, .readN, .address, .dataIn, .dataOut,
    .thrLoad, .thrFull, .rhrTake, .rhrFlush, .rhrLoad, .rhrFull, .rhrEntry,
    .txIdle, .txEn, .rxEn, .loopback,
    .dtrN, .rtsN, .rxRdyN, .txRdyN, .txEmtN
  );

  holdReg #(.payloadT(charT)) txHold (
    .BRCLK, .cmd_resetError,
    .load(thrLoad), .loadData(dataIn), .take(thrTake),
    .flush(!txEn),                         // THR empty while disabled
    .data(thrData), .full(thrFull)
  );

  uartTx u_uartTx (
    .BRCLK, .cmd_resetError, .enable(txEn), .charValid(thrFull),
    .charIn(thrData), .take(thrTake), .txd, .idle(txIdle)
  );

  uartRx u_uartRx (
    .BRCLK, .cmd_resetError, .enable(rxEn), .loopback, .rxd,
    .txdLoop(txd), .done(rhrLoad), .entry(rxEntry)
  );

  holdReg #(.payloadT(rxEntryT)) rxHold (
    .BRCLK, .cmd_resetError,
    .load(rhrLoad), .loadData(rxEntry), .take(rhrTake), .flush(rhrFlush),
    .data(rhrEntry), .full(rhrFull)
  );

endmodule

`default_nettype wire

//--- logic/uartTx.sv
/*
  Transmit shifter. Takes one character from the holding register when idle
  and sends start bit, 8 data bits LSB first and stop bit, each BIT_TICKS
  cycles long. Dropping enable returns it to idle at once.
*/
`timescale 1ns/1ps
`default_nettype none

`include "uartTiming_consts.svh"

module uartTx (
  input  wire logic          BRCLK,
  input  wire logic          cmd_resetError,
  input  wire logic          enable,
  input  wire logic          charValid,     // THR full
  input  wire uartPkg::charT charIn,
  output logic               take,          // Empties the THR
  output logic               txd,
  output logic               idle
);

  import uartPkg::*;

  localparam int CntW = $clog2(`BIT_TICKS);

  typedef enum logic [1:0] {IDLE, START, DATA, STOP} txStateT;

  txStateT         state;
  logic [CntW-1:0] tickCnt;                 // Cycles within a bit
  logic [2:0]      bitIdx;                  // Data bit being sent
  charT            shiftCopy;               // Frees the THR for the next char
  logic            bitEnd;

  assign bitEnd = (tickCnt == CntW'(`BIT_TICKS - 1));
  assign idle   = (state == IDLE);
  assign take   = enable && idle && charValid;

  // ------------------------------------------------------------
  // Frame FSM
  // ------------------------------------------------------------
  always_ff @(posedge BRCLK) begin
    if (cmd_resetError || !enable) begin
      state   <= IDLE;
      txd     <= 1'b1;                      // Line marks when off
      tickCnt <= '0;
      bitIdx  <= '0;
    end else begin
      tickCnt <= bitEnd ? '0 : tickCnt + 1'b1;
      case (state)
        IDLE: begin
          tickCnt <= '0;
          if (take) begin
            state <= START;
            txd   <= 1'b0;                  // Start bit from next cycle
          end
        end
        START: if (bitEnd) begin
          state  <= DATA;
          bitIdx <= '0;
          txd    <= shiftCopy[0];           // LSB first
        end
        DATA: if (bitEnd) begin
          if (bitIdx == 3'd7) begin
            state <= STOP;
            txd   <= 1'b1;
          end else begin
            bitIdx <= bitIdx + 3'd1;
            txd    <= shiftCopy[bitIdx + 3'd1];
          end
        end
        STOP: if (bitEnd) state <= IDLE;    // Idle 160 cycles after take
        default: state <= IDLE;
      endcase
    end
  end

  // Own copy of the character, loaded at take
  always_ff @(posedge BRCLK) begin
    if (take) begin
      shiftCopy <= charIn;
    end
  end

endmodule

`default_nettype wire

//--- uartTop.f
+incdir+logic
logic/uartPkg.sv
logic/holdReg.sv
logic/hostRegs.sv
logic/uartTx.sv
logic/uartRx.sv
logic/uartTop.sv
verif/uartTopTb.sv

//--- verif/uartTopTb.sv
/*
  Table-driven testbench for the UART top level. Each table row is a bus
  write, a bus read, an rxd frame, a decoded txd frame or a pin check, and
  a loop applies the rows in order. Run it as the simulation top.
*/
`timescale 1ns/1ps
`default_nettype none

`include "uartTiming_consts.svh"

module uartTopTb;

  import uartPkg::*;

  // Step kinds of a table row
  localparam logic [2:0] stepWrite = 3'd0, stepRead = 3'd1, stepSend = 3'd2;
  localparam logic [2:0] stepWaitTx = 3'd3, stepPins = 3'd4;

  // Command bits from txEn in bit 0 up to mode in bits 7:6
  localparam charT cmdTxEn = 8'h01, cmdDtrLow = 8'h02, cmdRxEn = 8'h04;
  localparam charT cmdSpare = 8'h08, cmdClrErr = 8'h10, cmdRtsLow = 8'h20;
  localparam charT cmdLocalLoop = 8'h80;

  localparam charT stThre = 8'h01 << `SR_THRE, stRxRdy = 8'h01 << `SR_RXRDY;
  localparam charT stTxEmt = 8'h01 << `SR_TXEMT, stOverrun = 8'h01 << `SR_OVERRUN;
  localparam charT stFrameErr = 8'h01 << `SR_FRAMEERR;

  localparam int txStartWait = 200;         // Cycles to find a start bit

  typedef struct packed {
    logic [2:0] kind;
    logic [1:0] addr;
    charT       data;                       // Write data or rxd frame byte
    logic       stopBit;                    // Stop level of an rxd frame
    charT       expVal;                     // Read value, txd byte or pin vector
  } rowT;

  logic BRCLK, cmd_resetError, ceN, readN, rxd;
  logic [1:0] address;
  charT dataIn, dataOut;
  logic txd, dtrN, rtsN, rxRdyN, txRdyN, txEmtN;

  rowT         rows [0:63];
  int          nRows, rowErrs, passCount, failCount, cycles, cycleLimit, i;
  charT        rnd [0:5];

  uartTop uut (
    .BRCLK, .cmd_resetError, .ceN, .readN, .address, .dataIn, .dataOut,
    .rxd, .txd, .dtrN, .rtsN, .rxRdyN, .txRdyN, .txEmtN
  );

  always #10 BRCLK = ~BRCLK;                // 20 ns period

  // Run limit from the table length
  always @(posedge BRCLK) begin
    cycles = cycles + 1;
    if (cycleLimit > 0 && cycles > cycleLimit) begin
      $display("Run stopped: %0d cycles passed and the table did not finish", cycleLimit);
      $display("test failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic checkChar(input string sig, input charT exp, input charT act);
    if (act !== exp) begin
      $display("** Error: %s expected %h got %h", sig, exp, act);
      rowErrs++;
    end
  endtask

  task automatic checkEntry(input string sig, input rxEntryT exp, input rxEntryT act);
    if (act !== exp) begin
      $display("** Error: %s expected %h got %h", sig, exp, act);
      rowErrs++;
    end
  endtask

  task automatic checkPin(input string sig, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error: %s expected %h got %h", sig, exp, act);
      rowErrs++;
    end
  endtask

  // ------------------------------------------------------------
  // Bus and serial line models
  // ------------------------------------------------------------
  task automatic writeBus(input logic [1:0] addr, input charT data);
    @(posedge BRCLK);
    #2;
    ceN     = 1'b0;                         // One-cycle write strobe
    readN   = 1'b1;
    address = addr;
    dataIn  = data;
    @(posedge BRCLK);
    #2;
    ceN = 1'b1;
  endtask

  task automatic readBus(input logic [1:0] addr, output charT got);
    @(posedge BRCLK);
    #2;
    ceN     = 1'b0;
    readN   = 1'b0;
    address = addr;
    @(posedge BRCLK);
    #2;
    ceN   = 1'b1;
    readN = 1'b1;
    got   = dataOut;                        // Loaded at the strobe edge
  endtask

  task automatic driveRxFrame(input charT data, input logic stopBit);
    logic [9:0] frame;
    int b;
    frame = {stopBit, data, 1'b0};          // Start, LSB first, stop
    @(posedge BRCLK);
    #2;
    for (b = 0; b < 10; b++) begin
      rxd = frame[b];
      repeat (`BIT_TICKS) @(posedge BRCLK);
      #2;
    end
    rxd = 1'b1;                             // Back to mark
  endtask

  task automatic decodeTxFrame(output rxEntryT frame, output bit late);
    int waitCnt;
    int b;
    waitCnt = 0;
    late    = 1'b0;
    frame   = '0;
    @(negedge BRCLK);
    while (txd !== 1'b0 && waitCnt < txStartWait) begin
      @(negedge BRCLK);
      waitCnt++;
    end
    if (txd !== 1'b0) begin
      late = 1'b1;
    end else begin
      repeat (`HALF_TICKS) @(negedge BRCLK);           // Middle of start bit
      checkPin("txd start bit", 1'b0, txd);
      for (b = 0; b < 8; b++) begin
        repeat (`BIT_TICKS) @(negedge BRCLK);
        frame.ch[b] = txd;
      end
      repeat (`BIT_TICKS) @(negedge BRCLK);
      frame.frameErr = !txd;                           // Stop should be high
      repeat (`HALF_TICKS + 2) @(negedge BRCLK);       // Rest of stop while flags settle
    end
  endtask

  // Pin vector order dtrN, rtsN, rxRdyN, txRdyN, txEmtN
  task automatic samplePins(input logic [4:0] exp);
    repeat (2) @(posedge BRCLK);            // Lets a THR take land
    @(negedge BRCLK);
    checkPin("dtrN", exp[4], dtrN);
    checkPin("rtsN", exp[3], rtsN);
    checkPin("rxRdyN", exp[2], rxRdyN);
    checkPin("txRdyN", exp[1], txRdyN);
    checkPin("txEmtN", exp[0], txEmtN);
  endtask

  // ------------------------------------------------------------
  // Table
  // ------------------------------------------------------------
  task automatic addRow(input logic [2:0] kind, input logic [1:0] addr, input charT data,
                        input logic stopBit, input charT expVal);
    rows[nRows] = {kind, addr, data, stopBit, expVal};
    nRows++;
  endtask

  task automatic buildTable;
    nRows = 0;
    addRow(stepPins, 2'd0, 8'h00, 1'b1, 8'b000_11111);         // All pins idle
    addRow(stepRead, `ADDR_STATUS, 8'h00, 1'b1, 8'h00);
    addRow(stepWrite, `ADDR_MODE, 8'hFF, 1'b1, 8'h00);          // Ignored
    addRow(stepRead, `ADDR_MODE, 8'h00, 1'b1, 8'h00);
    addRow(stepWrite, `ADDR_CMD, cmdDtrLow | cmdSpare | cmdRtsLow, 1'b1, 8'h00);
    addRow(stepRead, `ADDR_CMD, 8'h00, 1'b1, cmdDtrLow | cmdSpare | cmdRtsLow);
    addRow(stepPins, 2'd0, 8'h00, 1'b1, 8'b000_00111);
    // Transmit path
    addRow(stepWrite, `ADDR_CMD, cmdTxEn, 1'b1, 8'h00);
    addRow(stepPins, 2'd0, 8'h00, 1'b1, 8'b000_11101);
    addRow(stepWrite, `ADDR_DATA, rnd[0], 1'b1, 8'h00);
    addRow(stepPins, 2'd0, 8'h00, 1'b1, 8'b000_11101);         // THR empty again
    addRow(stepWaitTx, 2'd0, 8'h00, 1'b1, rnd[0]);
    addRow(stepPins, 2'd0, 8'h00, 1'b1, 8'b000_11100);
    addRow(stepRead, `ADDR_STATUS, 8'h00, 1'b1, stThre | stTxEmt);
    addRow(stepRead, `ADDR_STATUS, 8'h00, 1'b1, stThre);        // TXEMT cleared by read
    addRow(stepPins, 2'd0, 8'h00, 1'b1, 8'b000_11101);
    // Receive path with overrun and frame error
    addRow(stepWrite, `ADDR_CMD, cmdRxEn, 1'b1, 8'h00);
    addRow(stepSend, 2'd0, rnd[1], 1'b1, 8'h00);
    addRow(stepPins, 2'd0, 8'h00, 1'b1, 8'b000_11011);
    addRow(stepRead, `ADDR_STATUS, 8'h00, 1'b1, stRxRdy);
    addRow(stepRead, `ADDR_DATA, 8'h00, 1'b1, rnd[1]);
    addRow(stepPins, 2'd0, 8'h00, 1'b1, 8'b000_11111);
    addRow(stepSend, 2'd0, rnd[2], 1'b1, 8'h00);
    addRow(stepSend, 2'd0, rnd[3], 1'b1, 8'h00);               // No read between
    addRow(stepRead, `ADDR_STATUS, 8'h00, 1'b1, stRxRdy | stOverrun);
    addRow(stepRead, `ADDR_DATA, 8'h00, 1'b1, rnd[3]);
    addRow(stepWrite, `ADDR_CMD, cmdRxEn | cmdClrErr, 1'b1, 8'h00);
    addRow(stepRead, `ADDR_STATUS, 8'h00, 1'b1, 8'h00);
    addRow(stepSend, 2'd0, rnd[4], 1'b0, 8'h00);               // Low stop bit
    addRow(stepRead, `ADDR_STATUS, 8'h00, 1'b1, stRxRdy | stFrameErr);
    addRow(stepRead, `ADDR_DATA, 8'h00, 1'b1, rnd[4]);
    addRow(stepWrite, `ADDR_CMD, cmdRxEn | cmdClrErr, 1'b1, 8'h00);
    addRow(stepRead, `ADDR_STATUS, 8'h00, 1'b1, 8'h00);
    // Local loopback
    addRow(stepWrite, `ADDR_CMD, cmdLocalLoop | cmdTxEn | cmdRxEn, 1'b1, 8'h00);
    addRow(stepWrite, `ADDR_DATA, rnd[5], 1'b1, 8'h00);
    addRow(stepWaitTx, 2'd0, 8'h00, 1'b1, rnd[5]);
    addRow(stepRead, `ADDR_STATUS, 8'h00, 1'b1, stThre | stRxRdy | stTxEmt);
    addRow(stepRead, `ADDR_DATA, 8'h00, 1'b1, rnd[5]);
    addRow(stepPins, 2'd0, 8'h00, 1'b1, 8'b000_11101);
  endtask

  function automatic string stepName(input logic [2:0] kind);
    case (kind)
      stepWrite:  return "write";
      stepRead:   return "read";
      stepSend:   return "rxframe";
      stepWaitTx: return "txframe";
      default:    return "pins";
    endcase
  endfunction

  task automatic applyRow(input int idx);
    rowT     r;
    charT    got;
    rxEntryT frame;
    bit      late;
    r       = rows[idx];
    rowErrs = 0;
    case (r.kind)
      stepWrite: writeBus(r.addr, r.data);
      stepRead: begin
        readBus(r.addr, got);
        checkChar("dataOut", r.expVal, got);
      end
      stepSend: driveRxFrame(r.data, r.stopBit);
      stepWaitTx: begin
        decodeTxFrame(frame, late);
        if (late) begin
          $display("Row %0d: no start bit showed up on txd in time", idx);
          rowErrs++;
        end else begin
          checkEntry("txd frame", rxEntryT'({1'b0, r.expVal}), frame);
        end
      end
      default: samplePins(r.expVal[4:0]);
    endcase
    if (rowErrs == 0) passCount++;
    else failCount++;
    $display("Row %0d %0s: %0s", idx, stepName(r.kind), (rowErrs == 0) ? "ok" : "FAILED");
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    BRCLK          = 1'b0;
    cmd_resetError = 1'b1;
    ceN            = 1'b1;
    readN          = 1'b1;
    address        = 2'd0;
    dataIn         = 8'h00;
    rxd            = 1'b1;                  // Line idles at mark
    cycles         = 0;
    cycleLimit     = 0;
    passCount      = 0;
    failCount      = 0;
    void'($urandom(58095));
    for (i = 0; i < 6; i++) rnd[i] = 8'($urandom);
    buildTable();
    cycleLimit = 200 * nRows + 100;
    repeat (2) @(posedge BRCLK);
    #2;
    cmd_resetError = 1'b0;
    for (i = 0; i < nRows; i++) applyRow(i);
    $display("Rows passed: %0d, rows failed: %0d", passCount, failCount);
    if (failCount == 0) $display("test passed");
    else $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire
